//--- arith_pkg.sv
// widths and step counts of the arithmetic datapath, imported by the datapath and counter
`default_nettype none

package arith_pkg;

   // operand and result width
   localparam int unsigned DATA_W = 64;

   // one prefix adder, one multiply operand
   localparam int unsigned HALF_W = 32;

   // one shift-and-add step per multiplier bit
   localparam int unsigned MUL_STEPS = 32;

   // step counter width
   localparam int unsigned STEP_W = 6;

endpackage : arith_pkg

`default_nettype wire

//--- arith_ctrl_pkg.sv
// opcode and state encodings plus the request and response structs of the arithmetic unit
`default_nettype none

package arith_ctrl_pkg;

   typedef enum logic [1:0] {
      OP_ADD  = 2'd0,
      OP_SUB  = 2'd1,
      OP_MULU = 2'd2
   } arith_op_e;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_ADD  = 2'd1,
      ST_MUL  = 2'd2,
      ST_DONE = 2'd3
   } arith_state_e;

   // MULU reads only the low half of a and b
   typedef struct packed {
      arith_op_e                    op;
      logic [arith_pkg::DATA_W-1:0] a;
      logic [arith_pkg::DATA_W-1:0] b;
   } arith_req_t;

   // carry is the no-borrow flag for SUB, zero for MULU
   typedef struct packed {
      logic [arith_pkg::DATA_W-1:0] result;
      logic                         carry;
   } arith_rsp_t;

endpackage : arith_ctrl_pkg

`default_nettype wire

//--- han_carlson_add32.sv
// 32-bit Han-Carlson prefix adder with carry in and out, chained in pairs by the datapath
`default_nettype none

module han_carlson_add32 (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic        cin,
   output logic [31:0] sum,
   output logic        cout
);

   logic [31:0] p;
   logic [31:0] g;

   // pair groups, entry i covers bits 2i+1 down to 2i
   logic [15:0] l0_g;
   logic [15:0] l0_p;
   logic [15:0] l1_g;
   logic [15:0] l1_p;
   logic [15:0] l2_g;
   logic [15:0] l2_p;
   logic [15:0] l3_g;
   logic [15:0] l3_p;
   logic [15:0] l4_g;
   logic [15:0] l4_p;

   // prefix from bit 0 up to each position
   logic [31:0] grp_g;
   logic [31:0] grp_p;
   logic [32:0] c;

   assign p = a ^ b;
   assign g = a & b;

   genvar i;

   generate
      for (i = 0; i < 16; i++) begin : g_pair
         assign l0_g[i] = g[2*i+1] | (p[2*i+1] & g[2*i]);
         assign l0_p[i] = p[2*i+1] & p[2*i];
      end

      // kogge-stone over the 16 pair groups, spans 1, 2, 4, 8
      for (i = 0; i < 16; i++) begin : g_lvl1
         if (i >= 1) begin : g_op
            assign l1_g[i] = l0_g[i] | (l0_p[i] & l0_g[i-1]);
            assign l1_p[i] = l0_p[i] & l0_p[i-1];
         end else begin : g_pass
            assign l1_g[i] = l0_g[i];
            assign l1_p[i] = l0_p[i];
         end
      end

      for (i = 0; i < 16; i++) begin : g_lvl2
         if (i >= 2) begin : g_op
            assign l2_g[i] = l1_g[i] | (l1_p[i] & l1_g[i-2]);
            assign l2_p[i] = l1_p[i] & l1_p[i-2];
         end else begin : g_pass
            assign l2_g[i] = l1_g[i];
            assign l2_p[i] = l1_p[i];
         end
      end

      for (i = 0; i < 16; i++) begin : g_lvl3
         if (i >= 4) begin : g_op
            assign l3_g[i] = l2_g[i] | (l2_p[i] & l2_g[i-4]);
            assign l3_p[i] = l2_p[i] & l2_p[i-4];
         end else begin : g_pass
            assign l3_g[i] = l2_g[i];
            assign l3_p[i] = l2_p[i];
         end
      end

      for (i = 0; i < 16; i++) begin : g_lvl4
         if (i >= 8) begin : g_op
            assign l4_g[i] = l3_g[i] | (l3_p[i] & l3_g[i-8]);
            assign l4_p[i] = l3_p[i] & l3_p[i-8];
         end else begin : g_pass
            assign l4_g[i] = l3_g[i];
            assign l4_p[i] = l3_p[i];
         end
      end

      // odd bits come straight from the tree, even bits need one more cell
      for (i = 0; i < 16; i++) begin : g_fill
         assign grp_g[2*i+1] = l4_g[i];
         assign grp_p[2*i+1] = l4_p[i];
         if (i == 0) begin : g_first
            assign grp_g[0] = g[0];
            assign grp_p[0] = p[0];
         end else begin : g_even
            assign grp_g[2*i] = g[2*i] | (p[2*i] & grp_g[2*i-1]);
            assign grp_p[2*i] = p[2*i] & grp_p[2*i-1];
         end
      end
   endgenerate

   // fold in the carry in
   assign c[0]    = cin;
   assign c[32:1] = grp_g | (grp_p & {32{cin}});

   assign sum  = p ^ c[31:0];
   assign cout = c[32];

endmodule : han_carlson_add32

`default_nettype wire

//--- step_counter.sv
// multiply step counter, flags the last shift-and-add step to the control FSM
`default_nettype none

module step_counter (
   input  logic clk,
   input  logic arst_n,
   input  logic clear,
   input  logic en,
   output logic last
);

   import arith_pkg::*;

   logic [STEP_W-1:0] cnt_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q <= '0;
      end else if (clear) begin
         cnt_q <= '0;
      end else if (en) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // high during the cycle of the final step
   assign last = (cnt_q == STEP_W'(MUL_STEPS - 1));

endmodule : step_counter

`default_nettype wire

//--- arith_ctrl_fsm.sv
// control FSM of the arithmetic unit, sequences one operation from start to done
`default_nettype none

module arith_ctrl_fsm (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      start,
   input  arith_ctrl_pkg::arith_op_e op,
   input  logic                      last,
   output logic                      load,
   output logic                      add_en,
   output logic                      mul_en,
   output logic                      cnt_clear,
   output logic                      cnt_en,
   output logic                      busy,
   output logic                      done
);

   import arith_ctrl_pkg::*;

   arith_state_e state_q;
   arith_state_e state_d;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (start) begin
               state_d = (op == OP_MULU) ? ST_MUL : ST_ADD;
            end
         end
         ST_ADD: begin
            state_d = ST_DONE;
         end
         ST_MUL: begin
            // step 32 happens on the edge that leaves this state
            if (last) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // start is only looked at in idle
   assign load      = (state_q == ST_IDLE) && start;
   assign cnt_clear = (state_q == ST_IDLE) && start;

   assign add_en = (state_q == ST_ADD);
   assign mul_en = (state_q == ST_MUL);
   assign cnt_en = (state_q == ST_MUL);

   assign busy = (state_q != ST_IDLE);
   assign done = (state_q == ST_DONE);

endmodule : arith_ctrl_fsm

`default_nettype wire

//--- arith_datapath.sv
// operand, product and result registers around two chained prefix adders
`default_nettype none

module arith_datapath (
   input  logic                       clk,
   input  logic                       arst_n,
   input  arith_ctrl_pkg::arith_req_t req,
   input  logic                       load,
   input  logic                       add_en,
   input  logic                       mul_en,
   output arith_ctrl_pkg::arith_rsp_t rsp
);

   import arith_pkg::*;
   import arith_ctrl_pkg::*;

   logic [DATA_W-1:0] a_q;
   logic [DATA_W-1:0] b_q;
   arith_op_e         op_q;

   // high half is the accumulator, low half starts as the multiplier
   logic [DATA_W-1:0] prod_q;

   logic [DATA_W-1:0] res_q;
   logic              carry_q;

   logic              mul_mode;
   logic [HALF_W-1:0] lo_a;
   logic [HALF_W-1:0] lo_b;
   logic              lo_cin;
   logic [HALF_W-1:0] lo_sum;
   logic              lo_cout;
   logic [HALF_W-1:0] hi_sum;
   logic              hi_cout;

   assign mul_mode = (op_q == OP_MULU);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         a_q     <= '0;
         b_q     <= '0;
         op_q    <= OP_ADD;
         prod_q  <= '0;
         res_q   <= '0;
         carry_q <= 1'b0;
      end else begin
         if (load) begin
            a_q  <= req.a;
            // subtract as a plus inverted b plus one
            b_q  <= (req.op == OP_SUB) ? ~req.b : req.b;
            op_q <= req.op;
            if (req.op == OP_MULU) begin
               prod_q <= {{HALF_W{1'b0}}, req.b[HALF_W-1:0]};
            end
         end
         if (add_en) begin
            res_q   <= {hi_sum, lo_sum};
            carry_q <= hi_cout;
         end
         if (mul_en) begin
            // 33-bit partial sum and the low half move right by one
            prod_q <= {lo_cout, lo_sum, prod_q[HALF_W-1:1]};
         end
      end
   end

   // multiplicand added only when the current multiplier bit is set
   assign lo_a   = mul_mode ? prod_q[DATA_W-1:HALF_W] : a_q[HALF_W-1:0];
   assign lo_b   = mul_mode ? (prod_q[0] ? a_q[HALF_W-1:0] : '0) : b_q[HALF_W-1:0];
   assign lo_cin = (op_q == OP_SUB);

   han_carlson_add32 lo_add (
      .a    (lo_a),
      .b    (lo_b),
      .cin  (lo_cin),
      .sum  (lo_sum),
      .cout (lo_cout)
   );

   han_carlson_add32 hi_add (
      .a    (a_q[DATA_W-1:HALF_W]),
      .b    (b_q[DATA_W-1:HALF_W]),
      .cin  (lo_cout),
      .sum  (hi_sum),
      .cout (hi_cout)
   );

   assign rsp.result = mul_mode ? prod_q : res_q;
   assign rsp.carry  = mul_mode ? 1'b0 : carry_q;

endmodule : arith_datapath

`default_nettype wire

//--- arith_unit_top.sv
// top level of the 64-bit arithmetic unit, start/busy/done interface around FSM and datapath
`default_nettype none

module arith_unit_top (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       start,
   input  arith_ctrl_pkg::arith_req_t req,
   output logic                       busy,
   output logic                       done,
   output arith_ctrl_pkg::arith_rsp_t rsp
);

   logic load;
   logic add_en;
   logic mul_en;
   logic cnt_clear;
   logic cnt_en;
   logic last;

   arith_ctrl_fsm u_fsm (
      .clk       (clk),
      .arst_n    (arst_n),
      .start     (start),
      .op        (req.op),
      .last      (last),
      .load      (load),
      .add_en    (add_en),
      .mul_en    (mul_en),
      .cnt_clear (cnt_clear),
      .cnt_en    (cnt_en),
      .busy      (busy),
      .done      (done)
   );

   step_counter u_cnt (
      .clk    (clk),
      .arst_n (arst_n),
      .clear  (cnt_clear),
      .en     (cnt_en),
      .last   (last)
   );

   arith_datapath u_dp (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .load   (load),
      .add_en (add_en),
      .mul_en (mul_en),
      .rsp    (rsp)
   );

endmodule : arith_unit_top

`default_nettype wire

//--- arith_unit_tb.sv
// self-checking testbench that runs ADD, SUB and MULU through the arithmetic unit in simulation
`default_nettype none

module arith_unit_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import arith_pkg::*;
   import arith_ctrl_pkg::*;

   localparam int DONE_TIMEOUT = 100;

   logic       clk;
   logic       arst_n;
   logic       start;
   arith_req_t req;
   logic       busy;
   logic       done;
   arith_rsp_t rsp;

   integer     seed;
   arith_req_t cur_req;
   arith_rsp_t exp_rsp;
   int         done_seen = 0;
   int         rsp_errors = 0;
   int         hold_errors = 0;
   int         timing_errors = 0;
   int         timeouts = 0;
   int         ops_run = 0;

   arith_unit_top UUT (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .req    (req),
      .busy   (busy),
      .done   (done),
      .rsp    (rsp)
   );

   always #10 clk = ~clk;

   // expected response from plain wide arithmetic
   function automatic arith_rsp_t ref_calc(input arith_req_t r);
      logic [DATA_W:0] wide;
      arith_rsp_t      e;
      wide = '0;
      e    = '0;
      case (r.op)
         OP_ADD: begin
            wide     = {1'b0, r.a} + {1'b0, r.b};
            e.result = wide[DATA_W-1:0];
            e.carry  = wide[DATA_W];
         end
         OP_SUB: begin
            wide     = {1'b0, r.a} - {1'b0, r.b};
            e.result = wide[DATA_W-1:0];
            e.carry  = (r.a >= r.b);
         end
         default: begin
            e.result = {{HALF_W{1'b0}}, r.a[HALF_W-1:0]} * {{HALF_W{1'b0}}, r.b[HALF_W-1:0]};
            e.carry  = 1'b0;
         end
      endcase
      return e;
   endfunction

   function automatic arith_req_t make_req(input arith_op_e op, input logic [DATA_W-1:0] a,
                                           input logic [DATA_W-1:0] b);
      arith_req_t r;
      r.op = op;
      r.a  = a;
      r.b  = b;
      return r;
   endfunction

   task automatic rand_req(output arith_req_t r);
      logic [31:0] sel;
      sel = $random(seed);
      r.a = {$random(seed), $random(seed)};
      r.b = {$random(seed), $random(seed)};
      case (sel[1:0])
         2'd0: r.op = OP_ADD;
         2'd1: r.op = OP_SUB;
         default: r.op = OP_MULU;
      endcase
   endtask

   // compare the response on every done cycle
   always @(negedge clk) begin
      if (arst_n && done) begin
         done_seen = done_seen + 1;
         if (rsp !== exp_rsp) begin
            $display("mismatch at %0t: %s a %h b %h gave %h carry %b, expected %h carry %b",
                     $time, cur_req.op.name(), cur_req.a, cur_req.b, rsp.result, rsp.carry,
                     exp_rsp.result, exp_rsp.carry);
            rsp_errors = rsp_errors + 1;
         end
      end
   end

   // runs one operation and, for extra_at above zero, pulses a second start while busy
   task automatic run_op(input arith_req_t r, input int extra_at);
      int         cycles;
      int         exp_cycles;
      int         seen_before;
      int         k;
      bit         got;
      arith_req_t junk;
      cycles      = 0;
      got         = 1'b0;
      exp_cycles  = (r.op == OP_MULU) ? MUL_STEPS + 1 : 2;
      seen_before = done_seen;
      cur_req     = r;
      exp_rsp     = ref_calc(r);
      ops_run++;
      rand_req(junk);
      @(posedge clk);
      start <= 1'b1;
      req   <= r;
      // first edge in the loop is the one that accepts start
      while (!got && cycles < DONE_TIMEOUT) begin
         @(posedge clk);
         if (extra_at > 0 && cycles == extra_at) begin
            start <= 1'b1;
            req   <= junk;
         end else begin
            start <= 1'b0;
         end
         @(negedge clk);
         cycles++;
         if (done) begin
            got = 1'b1;
         end else if (!busy) begin
            $display("mismatch at %0t: busy low in cycle %0d of %s",
                     $time, cycles, r.op.name());
            timing_errors++;
         end
      end
      if (!got) begin
         $display("timeout at %0t: done never arrived for %s", $time, r.op.name());
         timeouts++;
      end else begin
         if (cycles != exp_cycles) begin
            $display("mismatch at %0t: %s done after %0d cycles, expected %0d",
                     $time, r.op.name(), cycles, exp_cycles);
            timing_errors++;
         end
         if (!busy) begin
            $display("mismatch at %0t: busy low while done is high", $time);
            timing_errors++;
         end
      end
      @(posedge clk);
      start <= 1'b0;
      for (k = 0; k < 4; k++) begin
         @(negedge clk);
         if (done || busy) begin
            $display("mismatch at %0t: done %b busy %b, %0d cycles after done",
                     $time, done, busy, k + 1);
            timing_errors++;
         end
         if (rsp !== exp_rsp) begin
            $display("mismatch at %0t: response not held after done, %h carry %b",
                     $time, rsp.result, rsp.carry);
            hold_errors++;
         end
      end
      if (got && done_seen != seen_before + 1) begin
         $display("mismatch at %0t: %0d done pulses for one operation",
                  $time, done_seen - seen_before);
         timing_errors++;
      end
   endtask

   initial begin
      arith_req_t r;
      int         i;
      int         total;
      seed   = 32'hba93;
      clk    = 1'b0;
      arst_n = 1'b0;
      start  = 1'b0;
      req    = '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         if (busy || done) begin
            $display("mismatch at %0t: busy %b done %b after reset", $time, busy, done);
            timing_errors++;
         end
      end

      run_op(make_req(OP_ADD, 64'hffff_ffff_ffff_ffff, 64'h1), 0);
      run_op(make_req(OP_ADD, 64'h0000_0000_ffff_ffff, 64'h1), 0);
      run_op(make_req(OP_ADD, 64'h1234_5678_8000_0000, 64'h0000_0001_8000_0000), 0);
      run_op(make_req(OP_ADD, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff), 0);
      run_op(make_req(OP_ADD, 64'h0, 64'h0), 0);

      run_op(make_req(OP_SUB, 64'd5, 64'd3), 0);
      run_op(make_req(OP_SUB, 64'd3, 64'd5), 0);
      run_op(make_req(OP_SUB, 64'h0, 64'h0), 0);
      run_op(make_req(OP_SUB, 64'h0, 64'h1), 0);
      run_op(make_req(OP_SUB, 64'h0000_0001_0000_0000, 64'h1), 0);
      run_op(make_req(OP_SUB, 64'hdead_beef_cafe_f00d, 64'hdead_beef_cafe_f00d), 0);

      run_op(make_req(OP_MULU, 64'h0, 64'h1234_5678), 0);
      run_op(make_req(OP_MULU, 64'h1, 64'h8765_4321), 0);
      run_op(make_req(OP_MULU, 64'hffff_ffff, 64'hffff_ffff), 0);
      // upper halves must not reach the product
      run_op(make_req(OP_MULU, 64'haaaa_aaaa_0000_0003, 64'h5555_5555_0000_0007), 0);

      // second start while busy and during the done cycle
      run_op(make_req(OP_ADD, 64'h0123_4567_89ab_cdef, 64'h1111_1111_1111_1111), 1);
      run_op(make_req(OP_SUB, 64'h10, 64'h20), 1);
      run_op(make_req(OP_MULU, 64'h0001_0003, 64'h0002_0005), 5);
      run_op(make_req(OP_MULU, 64'hffff_0000, 64'h0000_ffff), 32);

      for (i = 0; i < 40; i++) begin
         rand_req(r);
         run_op(r, 0);
      end

      total = rsp_errors + hold_errors + timing_errors + timeouts;
      $display("ops %0d, done pulses %0d, response errors %0d, hold errors %0d, %s %0d, %s %0d",
               ops_run, done_seen, rsp_errors, hold_errors, "timing errors", timing_errors,
               "timeouts", timeouts);
      if (total == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule : arith_unit_tb

`default_nettype wire

//--- verilog.f
arith_pkg.sv
arith_ctrl_pkg.sv
han_carlson_add32.sv
step_counter.sv
arith_ctrl_fsm.sv
arith_datapath.sv
arith_unit_top.sv
arith_unit_tb.sv

//--- run.sh
#!/bin/sh
# builds the arithmetic unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=arith_unit_sim

verilator --binary --timing --timescale 1ns/100ps \
   --top-module arith_unit_tb -f verilog.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
